// File: ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // One write on the broadcast settings bus
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // Configuration of one receive channel
   typedef struct packed {
      logic [31:0] phase_inc;
      logic [17:0] scale;
      logic [5:0]  shift;
      logic [7:0]  rate;
      logic        realmode;
      logic        swap_iq;
   } ddc_cfg_t;

   // Register offsets inside a channel window
   localparam int REG_PHASE = 0;
   localparam int REG_GAIN  = 1;
   localparam int REG_RATE  = 2;
   localparam int REG_MODE  = 3;

endpackage

`default_nettype wire

// File: dsp_pkg.sv
`default_nettype none

package dsp_pkg;

   typedef logic signed [23:0] fe_word_t;
   typedef logic signed [24:0] cordic_word_t;
   typedef logic [23:0]        phase_t;
   typedef logic signed [15:0] out_word_t;

   typedef struct packed {
      fe_word_t i;
      fe_word_t q;
   } iq24_t;

   typedef struct packed {
      out_word_t i;
      out_word_t q;
   } iq16_t;

   // Sample on the shared output bus, tagged with its channel
   typedef struct packed {
      logic  chan;
      iq16_t iq;
   } rx_sample_t;

   localparam int CIC_STAGES    = 4;
   localparam int CORDIC_STAGES = 20;

   // Saturate a wide signed value to the frontend sample width
   function automatic fe_word_t sat_fe(input logic signed [63:0] v);
      if (v > 64'sd8388607)
         return 24'sh7fffff;
      else if (v < -64'sd8388608)
         return 24'sh800000;
      else
         return v[23:0];
   endfunction

endpackage

`default_nettype wire

// File: ddc_settings.sv
`timescale 1ns/10ps
`default_nettype none

module ddc_settings #(
   parameter int BASE = 0
) (
   input  logic                clk,
   input  logic                rst,
   input  ctrl_pkg::set_bus_t  set_bus_i,
   output ctrl_pkg::ddc_cfg_t  cfg_o
);

   localparam ctrl_pkg::set_addr_t ADDR_PHASE = 8'(BASE + ctrl_pkg::REG_PHASE);
   localparam ctrl_pkg::set_addr_t ADDR_GAIN  = 8'(BASE + ctrl_pkg::REG_GAIN);
   localparam ctrl_pkg::set_addr_t ADDR_RATE  = 8'(BASE + ctrl_pkg::REG_RATE);
   localparam ctrl_pkg::set_addr_t ADDR_MODE  = 8'(BASE + ctrl_pkg::REG_MODE);

   logic hit_phase;
   logic hit_gain;
   logic hit_rate;
   logic hit_mode;

   assign hit_phase = set_bus_i.stb && (set_bus_i.addr == ADDR_PHASE);
   assign hit_gain  = set_bus_i.stb && (set_bus_i.addr == ADDR_GAIN);
   assign hit_rate  = set_bus_i.stb && (set_bus_i.addr == ADDR_RATE);
   assign hit_mode  = set_bus_i.stb && (set_bus_i.addr == ADDR_MODE);

   always_ff @(posedge clk) begin
      if (rst) begin
         // Unity scale and decimate by 4 until software says otherwise
         cfg_o <= '{phase_inc: '0, scale: 18'd1, shift: '0, rate: 8'd4,
                    realmode: 1'b0, swap_iq: 1'b0};
      end
      else begin
         if (hit_phase)
            cfg_o.phase_inc <= set_bus_i.data;
         if (hit_gain)
         begin
            cfg_o.scale <= set_bus_i.data[17:0];
            cfg_o.shift <= set_bus_i.data[23:18];
         end
         if (hit_rate)
            cfg_o.rate <= set_bus_i.data[7:0];
         if (hit_mode)
         begin
            cfg_o.swap_iq  <= set_bus_i.data[0];
            cfg_o.realmode <= set_bus_i.data[1];
         end
      end
   end

   // Output merging relies on at least one idle cycle between CIC strobes
   a_rate_min: assert property (@(posedge clk) disable iff (rst)
      hit_rate |-> (set_bus_i.data[7:0] >= 8'd2));

endmodule

`default_nettype wire

// File: cordic_rotator.sv
`timescale 1ns/10ps
`default_nettype none

module cordic_rotator (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  en_i,
   input  dsp_pkg::cordic_word_t x_i,
   input  dsp_pkg::cordic_word_t y_i,
   input  dsp_pkg::phase_t       phase_i,
   output dsp_pkg::fe_word_t     x_o,
   output dsp_pkg::fe_word_t     y_o
);

   localparam int N  = dsp_pkg::CORDIC_STAGES;
   localparam int ZW = $bits(dsp_pkg::phase_t);
   // Two guard bits hold the CORDIC gain of about 1.6468
   localparam int W  = $bits(dsp_pkg::cordic_word_t) + 2;

   typedef logic signed [W-1:0] cw_t;

   typedef struct packed {
      cw_t             x;
      cw_t             y;
      dsp_pkg::phase_t z;
   } rot_t;

   // atan(2^-k) scaled so that 2^24 is a full turn
   localparam dsp_pkg::phase_t ATAN [N] = '{
      24'd2097152, 24'd1238021, 24'd654136, 24'd332050,
      24'd166669,  24'd83416,   24'd41718,  24'd20860,
      24'd10430,   24'd5215,    24'd2608,   24'd1304,
      24'd652,     24'd326,     24'd163,    24'd81,
      24'd41,      24'd20,      24'd10,     24'd5
   };

   rot_t pre;
   rot_t pipe [N];

   // One shift-add step, turning toward a zero residual angle
   function automatic rot_t rot_step(input rot_t r, input int k);
      rot_t n;
      if (r.z[ZW-1]) begin
         n.x = r.x + (r.y >>> k);
         n.y = r.y - (r.x >>> k);
         n.z = r.z + ATAN[k];
      end
      else begin
         n.x = r.x - (r.y >>> k);
         n.y = r.y + (r.x >>> k);
         n.z = r.z - ATAN[k];
      end
      return n;
   endfunction

   // Quadrant pre-rotation, phases in the left half plane turn by 180 degrees
   always_comb begin
      if (phase_i[ZW-1] ^ phase_i[ZW-2]) begin
         pre.x = -cw_t'(x_i);
         pre.y = -cw_t'(y_i);
         pre.z = phase_i ^ {1'b1, {(ZW-1){1'b0}}};
      end
      else begin
         pre.x = cw_t'(x_i);
         pre.y = cw_t'(y_i);
         pre.z = phase_i;
      end
   end

   always_ff @(posedge clk) begin
      if (en_i) begin
         pipe[0] <= rot_step(pre, 0);
         for (int k = 1; k < N; k++)
         begin
            pipe[k] <= rot_step(pipe[k-1], k);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         x_o <= '0;
         y_o <= '0;
      end
      else if (en_i) begin
         x_o <= dsp_pkg::sat_fe(64'(pipe[N-1].x));
         y_o <= dsp_pkg::sat_fe(64'(pipe[N-1].y));
      end
   end

endmodule

`default_nettype wire

// File: cic_decimator.sv
`timescale 1ns/10ps
`default_nettype none

module cic_decimator (
   input  logic           clk,
   input  logic           rst,
   input  logic           run_i,
   input  logic [7:0]     rate_i,
   input  logic [5:0]     shift_i,
   input  dsp_pkg::iq24_t din_i,
   output dsp_pkg::iq24_t dout_o,
   output logic           stb_o
);

   localparam int NS = dsp_pkg::CIC_STAGES;
   // Growth of 4 stages at a rate of up to 255 is 32 bits
   localparam int AW = $bits(dsp_pkg::fe_word_t) + 32;

   typedef logic signed [AW-1:0] acc_t;

   // Index 0 is I, index 1 is Q
   acc_t              integ [2][NS];
   acc_t              dly   [2][NS];
   acc_t              diff  [2][NS+1];
   dsp_pkg::fe_word_t din   [2];
   dsp_pkg::fe_word_t dout  [2];
   logic [7:0]        cnt;
   logic              comb_stb;

   assign din = '{din_i.i, din_i.q};

   assign comb_stb = run_i && (cnt == 8'd0);

   // Comb chain evaluated in the strobe cycle
   always_comb begin
      for (int c = 0; c < 2; c++)
      begin
         diff[c][0] = integ[c][NS-1];
         for (int s = 0; s < NS; s++)
         begin
            diff[c][s+1] = diff[c][s] - dly[c][s];
         end
         dout[c] = dsp_pkg::sat_fe(64'(diff[c][NS] >>> shift_i));
      end
   end

   always_ff @(posedge clk) begin
      if (rst || !run_i) begin
         cnt <= rate_i - 8'd1;
         for (int c = 0; c < 2; c++)
         begin
            for (int s = 0; s < NS; s++)
            begin
               integ[c][s] <= '0;
               dly[c][s]   <= '0;
            end
         end
      end
      else begin
         cnt <= (cnt == 8'd0) ? rate_i - 8'd1 : cnt - 8'd1;
         for (int c = 0; c < 2; c++)
         begin
            integ[c][0] <= integ[c][0] + acc_t'(din[c]);
            for (int s = 1; s < NS; s++)
            begin
               integ[c][s] <= integ[c][s] + integ[c][s-1];
            end
            if (comb_stb)
            begin
               for (int s = 0; s < NS; s++)
               begin
                  dly[c][s] <= diff[c][s];
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst)
         stb_o <= 1'b0;
      else
         stb_o <= comb_stb;
   end

   always_ff @(posedge clk) begin
      if (comb_stb)
         dout_o <= '{i: dout[0], q: dout[1]};
   end

   a_stb_gap: assert property (@(posedge clk) disable iff (rst) stb_o |=> !stb_o);

endmodule

`default_nettype wire

// File: gain_round.sv
`timescale 1ns/10ps
`default_nettype none

module gain_round (
   input  logic           clk,
   input  logic           rst,
   input  logic [17:0]    scale_i,
   input  dsp_pkg::iq24_t din_i,
   input  logic           stb_i,
   output dsp_pkg::iq16_t dout_o,
   output logic           stb_o
);

   typedef logic signed [17:0] mul_in_t;
   typedef logic signed [35:0] prod_t;

   logic  stb_mul;
   prod_t prod_i;
   prod_t prod_q;

   // Round half up from 24 to 18 bits
   function automatic mul_in_t round18(input dsp_pkg::fe_word_t v);
      logic signed [24:0] sum;
      sum = 25'(v) + 25'sd32;
      if (sum[24] != sum[23])
         return 18'sh1ffff;
      else
         return sum[23:6];
   endfunction

   // Take product bits 33..18 with rounding and saturate
   function automatic dsp_pkg::out_word_t round16(input prod_t p);
      logic signed [36:0] sum;
      logic signed [18:0] top;
      sum = 37'(p) + 37'sd131072;
      top = sum[36:18];
      if (top > 19'sd32767)
         return 16'sh7fff;
      else if (top < -19'sd32768)
         return 16'sh8000;
      else
         return top[15:0];
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         stb_mul <= 1'b0;
         stb_o   <= 1'b0;
      end
      else begin
         stb_mul <= stb_i;
         stb_o   <= stb_mul;
      end
   end

   always_ff @(posedge clk) begin
      // Scale is unsigned, so it gets a zero sign bit
      if (stb_i) begin
         prod_i <= prod_t'(round18(din_i.i)) * prod_t'($signed({1'b0, scale_i}));
         prod_q <= prod_t'(round18(din_i.q)) * prod_t'($signed({1'b0, scale_i}));
      end
      if (stb_mul) begin
         dout_o.i <= round16(prod_i);
         dout_o.q <= round16(prod_q);
      end
   end

endmodule

`default_nettype wire

// File: ddc_chain.sv
`timescale 1ns/10ps
`default_nettype none

module ddc_chain #(
   parameter int BASE = 0,
   parameter int CHAN = 0
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               run_i,
   input  ctrl_pkg::set_bus_t set_bus_i,
   input  dsp_pkg::iq24_t     fe_i,
   output dsp_pkg::iq16_t     iq_o,
   output logic               stb_o
);

   localparam int PW = $bits(dsp_pkg::phase_t);

   ctrl_pkg::ddc_cfg_t cfg;
   dsp_pkg::iq24_t     fe_mux;
   dsp_pkg::iq24_t     mixed;
   dsp_pkg::iq24_t     cic_out;
   logic               cic_stb;
   logic [31:0]        phase;

   ddc_settings #(.BASE(BASE)) u_settings (
      .clk,
      .rst,
      .set_bus_i,
      .cfg_o (cfg)
   );

   // Input mux so a real signal can come in on either input
   always_ff @(posedge clk) begin
      if (cfg.swap_iq) begin
         fe_mux.i <= fe_i.q;
         fe_mux.q <= cfg.realmode ? '0 : fe_i.i;
      end
      else begin
         fe_mux.i <= fe_i.i;
         fe_mux.q <= cfg.realmode ? '0 : fe_i.q;
      end
   end

   // NCO phase accumulator
   always_ff @(posedge clk) begin
      if (rst || !run_i)
         phase <= '0;
      else
         phase <= phase + cfg.phase_inc;
   end

   cordic_rotator u_cordic (
      .clk,
      .rst,
      .en_i    (run_i),
      .x_i     (dsp_pkg::cordic_word_t'(fe_mux.i)),
      .y_i     (dsp_pkg::cordic_word_t'(fe_mux.q)),
      .phase_i (phase[31:32-PW]),
      .x_o     (mixed.i),
      .y_o     (mixed.q)
   );

   cic_decimator u_cic (
      .clk,
      .rst,
      .run_i,
      .rate_i  (cfg.rate),
      .shift_i (cfg.shift),
      .din_i   (mixed),
      .dout_o  (cic_out),
      .stb_o   (cic_stb)
   );

   gain_round u_gain (
      .clk,
      .rst,
      .scale_i (cfg.scale),
      .din_i   (cic_out),
      .stb_i   (cic_stb),
      .dout_o  (iq_o),
      .stb_o
   );

   // The channel tag on the merged bus is a single bit
   a_chan_range: assert property (@(posedge clk) CHAN inside {0, 1});

endmodule

`default_nettype wire

// File: rx_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module rx_arbiter (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [1:0]           stb_i,
   input  dsp_pkg::iq16_t [1:0] iq_i,
   output dsp_pkg::rx_sample_t  sample_o,
   output logic                 strobe_o
);

   logic [1:0]           pend;
   logic [1:0]           req;
   logic [1:0]           gnt;
   logic                 prio;
   dsp_pkg::iq16_t [1:0] held;
   dsp_pkg::iq16_t [1:0] cur;

   // A fresh strobe competes in its own cycle, a held entry waits one more
   always_comb begin
      req = pend | stb_i;
      for (int c = 0; c < 2; c++)
      begin
         cur[c] = pend[c] ? held[c] : iq_i[c];
      end
      gnt = (&req) ? (2'b01 << prio) : req;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pend     <= '0;
         prio     <= 1'b0;
         strobe_o <= 1'b0;
      end
      else begin
         pend     <= req & ~gnt;
         strobe_o <= |req;
         if (|req)
            prio <= ~gnt[1];   // loser of this round wins the next tie
      end
   end

   always_ff @(posedge clk) begin
      for (int c = 0; c < 2; c++)
      begin
         if (!pend[c])
            held[c] <= iq_i[c];
      end
      if (|req)
         sample_o <= '{chan: gnt[1], iq: cur[gnt[1]]};
   end

   a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
      (stb_i & pend) == 2'b00);

endmodule

`default_nettype wire

// File: ddc_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module ddc_rx_top #(
   parameter int CHAN_STRIDE = 8
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                run_i,
   input  ctrl_pkg::set_bus_t  set_bus_i,
   input  dsp_pkg::iq24_t      fe0_i,
   input  dsp_pkg::iq24_t      fe1_i,
   output dsp_pkg::rx_sample_t sample_o,
   output logic                strobe_o
);

   dsp_pkg::iq24_t [1:0] fe;
   dsp_pkg::iq16_t [1:0] chain_iq;
   logic [1:0]           chain_stb;

   assign fe = {fe1_i, fe0_i};

   // Each channel decodes its own settings window
   for (genvar c = 0; c < 2; c++) begin : g_chan
      ddc_chain #(
         .BASE (c * CHAN_STRIDE),
         .CHAN (c)
      ) u_chain (
         .clk,
         .rst,
         .run_i,
         .set_bus_i,
         .fe_i  (fe[c]),
         .iq_o  (chain_iq[c]),
         .stb_o (chain_stb[c])
      );
   end

   rx_arbiter u_arbiter (
      .clk,
      .rst,
      .stb_i    (chain_stb),
      .iq_i     (chain_iq),
      .sample_o,
      .strobe_o
   );

endmodule

`default_nettype wire

// File: tb_ddc_rx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ddc_rx;

   localparam int          CLK_PERIOD   = 4;
   localparam int          RST_CYCLES   = 16;
   localparam int          CHAN_STRIDE  = 8;
   localparam logic [31:0] SEED         = 32'haf21_2863;
   localparam real         CORDIC_GAIN  = 1.6468;
   localparam int          IDLE_CYCLES  = 200;
   localparam int          COUNT_CYCLES = 1600;
   localparam int          CFG_CYCLES   = 16;
   localparam int          SETTLE       = 64;
   localparam int          DRAIN        = 16;
   localparam int          DC_SAMPLES   = 16;
   localparam int          ROT_SAMPLES  = 1100;
   localparam int          ARB_CYCLES   = 800;
   localparam int          DC_CYCLES    = CFG_CYCLES + SETTLE + DC_SAMPLES * 4 + DRAIN;
   localparam int          TEST_CYCLES  = RST_CYCLES + IDLE_CYCLES
                                        + CFG_CYCLES + COUNT_CYCLES + DRAIN
                                        + 3 * DC_CYCLES
                                        + CFG_CYCLES + SETTLE + ROT_SAMPLES * 4 + DRAIN
                                        + CFG_CYCLES + SETTLE + ARB_CYCLES + DRAIN;

   logic                clk;
   logic                rst;
   logic                run;
   ctrl_pkg::set_bus_t  set_bus;
   dsp_pkg::iq24_t      fe0;
   dsp_pkg::iq24_t      fe1;
   dsp_pkg::rx_sample_t sample;
   logic                strobe;

   // Received samples sorted by channel tag
   dsp_pkg::iq16_t samp0[$];
   dsp_pkg::iq16_t samp1[$];

   ddc_rx_top #(
      .CHAN_STRIDE (CHAN_STRIDE)
   ) UUT (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run),
      .set_bus_i (set_bus),
      .fe0_i     (fe0),
      .fe1_i     (fe1),
      .sample_o  (sample),
      .strobe_o  (strobe)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(TEST_CYCLES * CLK_PERIOD * 2);
      $display("Watchdog expired after %0d ns before all tests completed",
               TEST_CYCLES * CLK_PERIOD * 2);
      fail_stop();
   end

   // Outputs are sampled in the middle of the cycle
   always @(negedge clk)
   begin
      if (!rst && strobe)
      begin
         if (sample.chan)
            samp1.push_back(sample.iq);
         else
            samp0.push_back(sample.iq);
      end
   end

   task automatic fail_stop();
      $display("Test FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check(input string name, input int got, input int exp, input int tol);
      int err;
      err = (got > exp) ? got - exp : exp - got;
      if (err > tol)
      begin
         $display("ERROR %s: got 0x%0h, expected 0x%0h, allowed error 0x%0h",
                  name, got, exp, tol);
         fail_stop();
      end
   endtask

   function automatic int sample_count(input int chan);
      return (chan == 1) ? samp1.size() : samp0.size();
   endfunction

   function automatic dsp_pkg::iq16_t sample_at(input int chan, input int idx);
      return (chan == 1) ? samp1[idx] : samp0[idx];
   endfunction

   function automatic int log2_exact(input int v);
      int n;
      n = 0;
      while ((1 << n) < v)
         n++;
      return n;
   endfunction

   // Top 16 bits of a 24-bit frontend level
   function automatic int top16(input int v);
      return v >>> 8;
   endfunction

   function automatic bit coin_flip();
      return ($urandom & 32'd1) != 32'd0;
   endfunction

   // Magnitude between 2^21 and 2^22, leaving headroom for the CORDIC gain
   function automatic int rand_level(input bit negative);
      int v;
      v = int'(32'h0020_0000 + ($urandom % 32'h0020_0000));
      return negative ? -v : v;
   endfunction

   task automatic write_reg(input ctrl_pkg::set_addr_t addr, input ctrl_pkg::set_data_t data);
      @(posedge clk);
      set_bus <= '{stb: 1'b1, addr: addr, data: data};
      @(posedge clk);
      set_bus <= '{stb: 1'b0, addr: '0, data: '0};
   endtask

   task automatic config_chan(input int chan, input logic [31:0] phase_inc, input int rate,
                              input bit swap_iq, input bit realmode);
      int          base;
      logic [5:0]  shift;
      logic [17:0] scale;
      base  = chan * CHAN_STRIDE;
      // CIC gain is rate^4
      shift = 6'(4 * log2_exact(rate));
      // Unity overall gain once the CORDIC gain is divided out
      scale = 18'($rtoi(65536.0 / CORDIC_GAIN + 0.5));
      write_reg(ctrl_pkg::set_addr_t'(base + ctrl_pkg::REG_PHASE), phase_inc);
      write_reg(ctrl_pkg::set_addr_t'(base + ctrl_pkg::REG_GAIN), {8'd0, shift, scale});
      write_reg(ctrl_pkg::set_addr_t'(base + ctrl_pkg::REG_RATE), 32'(rate));
      write_reg(ctrl_pkg::set_addr_t'(base + ctrl_pkg::REG_MODE),
                {30'd0, realmode, swap_iq});
   endtask

   task automatic drive_fe(input int i0, input int q0, input int i1, input int q1);
      @(posedge clk);
      fe0 <= '{i: dsp_pkg::fe_word_t'(i0), q: dsp_pkg::fe_word_t'(q0)};
      fe1 <= '{i: dsp_pkg::fe_word_t'(i1), q: dsp_pkg::fe_word_t'(q1)};
   endtask

   task automatic start_run(input int settle);
      @(posedge clk);
      run <= 1'b1;
      repeat (settle) @(posedge clk);
      samp0.delete();
      samp1.delete();
   endtask

   task automatic stop_run();
      @(posedge clk);
      run <= 1'b0;
      repeat (DRAIN) @(posedge clk);
      samp0.delete();
      samp1.delete();
   endtask

   task automatic wait_samples(input int chan, input int n, input int rate);
      int limit;
      int cycles;
      limit  = n * rate + 100;
      cycles = 0;
      while (sample_count(chan) < n)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > limit)
         begin
            $display("Channel %0d delivered only %0d of %0d samples within %0d cycles",
                     chan, sample_count(chan), n, limit);
            fail_stop();
         end
      end
   endtask

   task automatic check_dc(input int chan, input int exp_i, input int exp_q, input int n);
      dsp_pkg::iq16_t s;
      for (int k = 0; k < n; k++)
      begin
         s = sample_at(chan, k);
         check($sformatf("sample_o.iq.i chan %0d", chan), int'(s.i), exp_i, 2);
         check($sformatf("sample_o.iq.q chan %0d", chan), int'(s.q), exp_q, 2);
      end
   endtask

   // Runs both channels at rate 4 and compares the settled DC outputs
   task automatic measure_dc(input int exp0, input int exp1);
      start_run(SETTLE);
      wait_samples(0, DC_SAMPLES, 4);
      wait_samples(1, DC_SAMPLES, 4);
      check_dc(0, exp0, 0, DC_SAMPLES);
      check_dc(1, exp1, 0, DC_SAMPLES);
      stop_run();
   endtask

   task automatic idle_test();
      repeat (IDLE_CYCLES)
      begin
         @(negedge clk);
         check("strobe_o", int'(strobe), 0, 0);
      end
   endtask

   task automatic rate_test();
      config_chan(0, 32'd0, 4, 1'b0, 1'b0);
      config_chan(1, 32'd0, 16, 1'b0, 1'b0);
      start_run(0);
      repeat (COUNT_CYCLES) @(posedge clk);
      check("strobe_o count chan 0", sample_count(0), COUNT_CYCLES / 4, 2);
      check("strobe_o count chan 1", sample_count(1), COUNT_CYCLES / 16, 2);
      stop_run();
   endtask

   task automatic dc_gain_test();
      int lvl0;
      int lvl1;
      lvl0 = rand_level(coin_flip());
      lvl1 = rand_level(coin_flip());
      drive_fe(lvl0, 0, lvl1, 0);
      for (int c = 0; c < 2; c++)
         config_chan(c, 32'd0, 4, 1'b0, 1'b0);
      measure_dc(top16(lvl0), top16(lvl1));
   endtask

   task automatic mode_mux_test();
      int lvl_i;
      int lvl_q;
      lvl_i = rand_level(1'b0);
      lvl_q = rand_level(1'b1);
      drive_fe(lvl_i, lvl_q, lvl_q, lvl_i);
      // Real signal arrives on Q and is moved over to I
      for (int c = 0; c < 2; c++)
         config_chan(c, 32'd0, 4, 1'b1, 1'b1);
      measure_dc(top16(lvl_q), top16(lvl_i));
      // Real signal on I, the nonzero Q input is dropped
      for (int c = 0; c < 2; c++)
         config_chan(c, 32'd0, 4, 1'b0, 1'b1);
      measure_dc(top16(lvl_i), top16(lvl_q));
   endtask

   task automatic nco_test();
      int             lvl;
      int             bound;
      int             mag;
      bit             q_pos;
      bit             q_neg;
      dsp_pkg::iq16_t s;
      lvl   = rand_level(1'b0);
      bound = top16(lvl) * 3 / 100;
      drive_fe(lvl, 0, lvl, 0);
      // One full turn takes 4096 clocks, about 1024 output samples
      for (int c = 0; c < 2; c++)
         config_chan(c, 32'h0010_0000, 4, 1'b0, 1'b0);
      start_run(SETTLE);
      wait_samples(0, ROT_SAMPLES, 4);
      wait_samples(1, ROT_SAMPLES, 4);
      for (int c = 0; c < 2; c++)
      begin
         q_pos = 1'b0;
         q_neg = 1'b0;
         for (int k = 0; k < ROT_SAMPLES; k++)
         begin
            s   = sample_at(c, k);
            mag = $rtoi($sqrt(real'(s.i) * real'(s.i) + real'(s.q) * real'(s.q)) + 0.5);
            check($sformatf("sample_o.iq magnitude chan %0d", c), mag, top16(lvl), bound);
            if (int'(s.q) > bound)
               q_pos = 1'b1;
            if (int'(s.q) < -bound)
               q_neg = 1'b1;
         end
         check($sformatf("sample_o.iq.q sign change chan %0d", c),
               int'(q_pos && q_neg), 1, 0);
      end
      stop_run();
   endtask

   task automatic arbiter_test();
      int lvl0;
      int lvl1;
      // Opposite signs tell the two channels apart on the shared bus
      lvl0 = rand_level(1'b0);
      lvl1 = rand_level(1'b1);
      drive_fe(lvl0, 0, lvl1, 0);
      for (int c = 0; c < 2; c++)
         config_chan(c, 32'd0, 2, 1'b0, 1'b0);
      start_run(SETTLE);
      repeat (ARB_CYCLES) @(posedge clk);
      check("strobe_o count chan 0", sample_count(0), ARB_CYCLES / 2, 2);
      check("strobe_o count chan 1", sample_count(1), ARB_CYCLES / 2, 2);
      check_dc(0, top16(lvl0), 0, sample_count(0));
      check_dc(1, top16(lvl1), 0, sample_count(1));
      stop_run();
   endtask

   initial
   begin
      int unsigned seed_ret;
      seed_ret = $urandom(SEED);
      rst      = 1'b1;
      run      = 1'b0;
      set_bus  = '0;
      fe0      = '0;
      fe1      = '0;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
      idle_test();
      rate_test();
      dc_gain_test();
      mode_mux_test();
      nco_test();
      arbiter_test();
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
ctrl_pkg.sv
dsp_pkg.sv
ddc_settings.sv
cordic_rotator.sv
cic_decimator.sv
gain_round.sv
ddc_chain.sv
rx_arbiter.sv
ddc_rx_top.sv
tb_ddc_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ddc_rx -f sources.f \
   && ./obj_dir/Vtb_ddc_rx 2>&1 | tee sim.log
grep -sqx "Test OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
